// File: design/vehicle_pkg.sv
// ------------------------------
// Plate type, vehicle class decoding and fee rates
// ------------------------------
package vehicle_pkg;

	typedef logic [15:0] plate_t; // Zero marks an empty space
	typedef logic [1:0] rate_t;

	localparam logic [3:0] PREFIX_HANDICAP = 4'b1001;
	localparam logic [3:0] PREFIX_HYBRID = 4'b1000;

	localparam rate_t RATE_HANDICAP = 2'd0;
	localparam rate_t RATE_HYBRID = 2'd1;
	localparam rate_t RATE_REGULAR = 2'd2;

	function automatic logic is_handicap(plate_t p);
		return p[15:12] == PREFIX_HANDICAP;
	endfunction

	function automatic logic is_hybrid(plate_t p);
		return p[15:12] == PREFIX_HYBRID;
	endfunction

	// Odd plate numbers are SUVs
	function automatic logic is_suv(plate_t p);
		return p[0];
	endfunction

	function automatic rate_t fee_rate(plate_t p);
		if (is_handicap(p))
			return RATE_HANDICAP;
		if (is_hybrid(p))
			return RATE_HYBRID;
		return RATE_REGULAR;
	endfunction

endpackage

// File: design/lot_pkg.sv
// ------------------------------
// Tower geometry and slot indexing, shared by the RTL and the bench
// ------------------------------
package lot_pkg;

	localparam int NUM_FLOORS = 7;
	localparam int NUM_SLOTS = 2 * NUM_FLOORS;
	localparam int FIRST_SLOT = 2; // Slots 0 and 1 would sit at the lobby
	localparam int LAST_SLOT = FIRST_SLOT + NUM_SLOTS - 1;

	typedef logic [2:0] floor_t;
	typedef logic [3:0] slot_t; // Floor in the upper bits, left space when bit 0 is low

	typedef vehicle_pkg::plate_t [LAST_SLOT:FIRST_SLOT] slot_plates_t;

	function automatic floor_t slot_floor(slot_t s);
		return s[3:1];
	endfunction

	// Odd floors hold SUVs
	function automatic logic is_suv_floor(floor_t f);
		return f[0];
	endfunction

	// Left spaces of floors 1 and 2 are kept for handicapped cars
	function automatic logic is_reserved(slot_t s);
		return (slot_floor(s) == 3'd1 || slot_floor(s) == 3'd2) && !s[0];
	endfunction

endpackage

// File: design/order_queue.sv
// ------------------------------
// Order FIFO, hands one park or fetch order to the elevator at a time
// ------------------------------
module order_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input logic clock,
	input logic reset,
	input logic park,
	input logic fetch,
	input vehicle_pkg::plate_t plate,
	input logic ready,
	output logic order_park,
	output logic order_fetch,
	output vehicle_pkg::plate_t order_plate
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	vehicle_pkg::plate_t plate_mem [QUEUE_DEPTH];
	logic kind_mem [QUEUE_DEPTH]; // High for a fetch
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + PTR_W'(1);
	endfunction

	assign full = count == CNT_W'(QUEUE_DEPTH);
	assign push = (park || fetch) && !full;
	// No pop while an issued order is still on its way out
	assign pop = ready && count != '0 && !order_park && !order_fetch;

	always_ff @(posedge clock) begin
		if (push) begin
			plate_mem[wr_ptr] <= plate;
			kind_mem[wr_ptr] <= fetch;
		end
		if (pop)
			order_plate <= plate_mem[rd_ptr]; // Held until the next pop
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			order_park <= 1'b0;
			order_fetch <= 1'b0;
		end else begin
			order_park <= pop && !kind_mem[rd_ptr];
			order_fetch <= pop && kind_mem[rd_ptr];
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + CNT_W'(1);
			else if (pop && !push)
				count <= count - CNT_W'(1);
		end
	end

	assert property (@(posedge clock) disable iff (reset) !(park && fetch));
	assert property (@(posedge clock) disable iff (reset) (park || fetch) |-> !full);

endmodule

// File: design/spot_finder.sv
// ------------------------------
// Picks a free space for a parking car or locates a plate to fetch
// ------------------------------
module spot_finder (
	input lot_pkg::slot_plates_t slot_plates,
	input logic full_sedan,
	input vehicle_pkg::plate_t order_plate,
	output lot_pkg::slot_t park_slot,
	output logic park_found,
	output lot_pkg::slot_t fetch_slot,
	output logic fetch_found
);

	logic suv_car;
	logic handicap_car;

	assign suv_car = vehicle_pkg::is_suv(order_plate);
	assign handicap_car = vehicle_pkg::is_handicap(order_plate);

	// Walk from the top down so the lowest floor and the left space win
	always_comb begin
		lot_pkg::slot_t s_idx;
		logic floor_ok;
		logic reserve_ok;
		park_slot = '0;
		park_found = 1'b0;
		for (int s = lot_pkg::LAST_SLOT; s >= lot_pkg::FIRST_SLOT; s--) begin
			s_idx = lot_pkg::slot_t'(s);
			if (suv_car)
				floor_ok = lot_pkg::is_suv_floor(lot_pkg::slot_floor(s_idx));
			else
				floor_ok = !lot_pkg::is_suv_floor(lot_pkg::slot_floor(s_idx))
					|| full_sedan; // Sedan overflow onto SUV floors
			reserve_ok = !lot_pkg::is_reserved(s_idx) || handicap_car;
			if (floor_ok && reserve_ok && slot_plates[s] == '0) begin
				park_slot = s_idx;
				park_found = 1'b1;
			end
		end
	end

	always_comb begin
		fetch_slot = '0;
		fetch_found = 1'b0;
		for (int s = lot_pkg::FIRST_SLOT; s <= lot_pkg::LAST_SLOT; s++) begin
			if (order_plate != '0 && slot_plates[s] == order_plate) begin
				fetch_slot = lot_pkg::slot_t'(s);
				fetch_found = 1'b1;
			end
		end
	end

endmodule

// File: design/slot_table.sv
// ------------------------------
// Plate held in every space, with free counts and full flags per floor class
// ------------------------------
module slot_table (
	input logic clock,
	input logic reset,
	input logic store,
	input logic take,
	input lot_pkg::slot_t target_slot,
	input vehicle_pkg::plate_t moving,
	output lot_pkg::slot_plates_t slot_plates,
	output logic [3:0] empty_suv,
	output logic [3:0] empty_sedan,
	output logic full_suv,
	output logic full_sedan
);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			slot_plates <= '0;
		end else begin
			for (int s = lot_pkg::FIRST_SLOT; s <= lot_pkg::LAST_SLOT; s++) begin
				if (take && target_slot == lot_pkg::slot_t'(s))
					slot_plates[s] <= '0;
				else if (store && target_slot == lot_pkg::slot_t'(s))
					slot_plates[s] <= moving; // Car leaves the elevator
			end
		end
	end

	// Reserved spaces stay out of both counts
	always_comb begin
		lot_pkg::slot_t s_idx;
		empty_suv = '0;
		empty_sedan = '0;
		for (int s = lot_pkg::FIRST_SLOT; s <= lot_pkg::LAST_SLOT; s++) begin
			s_idx = lot_pkg::slot_t'(s);
			if (!lot_pkg::is_reserved(s_idx) && slot_plates[s] == '0) begin
				if (lot_pkg::is_suv_floor(lot_pkg::slot_floor(s_idx)))
					empty_suv = empty_suv + 4'd1;
				else
					empty_sedan = empty_sedan + 4'd1;
			end
		end
	end

	assign full_suv = empty_suv == '0;
	assign full_sedan = empty_sedan == '0;

	assert property (@(posedge clock) disable iff (reset) store |-> slot_plates[target_slot] == '0);
	assert property (@(posedge clock) disable iff (reset) take |-> slot_plates[target_slot] != '0);

endmodule

// File: design/fee_bank.sv
// ------------------------------
// One saturating fee meter per space, read out for the target space
// ------------------------------
module fee_bank #(
	parameter int FEE_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	input lot_pkg::slot_plates_t slot_plates,
	input lot_pkg::slot_t target_slot,
	output logic [FEE_WIDTH-1:0] slot_fee
);

	localparam int SUM_W = FEE_WIDTH + 1;

	logic [FEE_WIDTH-1:0] meter [lot_pkg::FIRST_SLOT:lot_pkg::LAST_SLOT];
	logic [FEE_WIDTH-1:0] meter_next [lot_pkg::FIRST_SLOT:lot_pkg::LAST_SLOT];

	always_comb begin
		logic [SUM_W-1:0] sum;
		for (int s = lot_pkg::FIRST_SLOT; s <= lot_pkg::LAST_SLOT; s++) begin
			sum = {1'b0, meter[s]} + SUM_W'(vehicle_pkg::fee_rate(slot_plates[s]));
			if (slot_plates[s] == '0)
				meter_next[s] = '0; // Empty space clears its meter
			else if (sum[FEE_WIDTH])
				meter_next[s] = '1; // Saturate
			else
				meter_next[s] = sum[FEE_WIDTH-1:0];
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int s = lot_pkg::FIRST_SLOT; s <= lot_pkg::LAST_SLOT; s++)
				meter[s] <= '0;
		end else begin
			for (int s = lot_pkg::FIRST_SLOT; s <= lot_pkg::LAST_SLOT; s++)
				meter[s] <= meter_next[s];
		end
	end

	// Next value, so the current occupied cycle is billed too
	always_comb begin
		slot_fee = '0;
		for (int s = lot_pkg::FIRST_SLOT; s <= lot_pkg::LAST_SLOT; s++) begin
			if (target_slot == lot_pkg::slot_t'(s))
				slot_fee = meter_next[s];
		end
	end

endmodule

// File: design/elevator_controller.sv
// ------------------------------
// Elevator FSM, carries cars up to a space or fetches them back to the lobby
// ------------------------------
module elevator_controller #(
	parameter int FEE_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	input logic order_park,
	input logic order_fetch,
	input vehicle_pkg::plate_t order_plate,
	input lot_pkg::slot_t park_slot,
	input logic park_found,
	input lot_pkg::slot_t fetch_slot,
	input logic fetch_found,
	input logic [FEE_WIDTH-1:0] slot_fee,
	output logic ready,
	output logic store,
	output logic take,
	output lot_pkg::slot_t target_slot,
	output lot_pkg::floor_t current_floor,
	output vehicle_pkg::plate_t moving,
	output logic car_out,
	output vehicle_pkg::plate_t car_out_plate,
	output logic [FEE_WIDTH-1:0] car_out_fee,
	output logic order_reject
);

	typedef enum logic [2:0] {
		st_idle,
		st_climb_park,
		st_climb_fetch,
		st_descend,
		st_deliver
	} state_t;

	state_t state;
	logic at_target;

	assign at_target = current_floor == lot_pkg::slot_floor(target_slot);
	assign ready = state == st_idle; // Idle only ever happens at the lobby
	assign store = state == st_climb_park && at_target;
	assign take = state == st_climb_fetch && at_target;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			target_slot <= '0;
			current_floor <= '0;
			moving <= '0;
			car_out <= 1'b0;
			order_reject <= 1'b0;
		end else begin
			car_out <= 1'b0;
			order_reject <= 1'b0;
			case (state)
				st_idle: begin
					if (order_park && park_found) begin
						target_slot <= park_slot;
						moving <= order_plate; // Car boards at the lobby
						current_floor <= lot_pkg::floor_t'(1);
						state <= st_climb_park;
					end else if (order_fetch && fetch_found) begin
						target_slot <= fetch_slot;
						current_floor <= lot_pkg::floor_t'(1);
						state <= st_climb_fetch;
					end else if (order_park || order_fetch) begin
						order_reject <= 1'b1;
					end
				end
				st_climb_park: begin
					if (at_target) begin
						moving <= '0;
						current_floor <= current_floor - lot_pkg::floor_t'(1);
						state <= (current_floor == lot_pkg::floor_t'(1)) ? st_idle : st_descend;
					end else begin
						current_floor <= current_floor + lot_pkg::floor_t'(1);
					end
				end
				st_climb_fetch: begin
					if (at_target) begin
						moving <= order_plate; // Queue holds the plate until its next pop
						current_floor <= current_floor - lot_pkg::floor_t'(1);
						state <= (current_floor == lot_pkg::floor_t'(1)) ? st_deliver : st_descend;
					end else begin
						current_floor <= current_floor + lot_pkg::floor_t'(1);
					end
				end
				st_descend: begin
					current_floor <= current_floor - lot_pkg::floor_t'(1);
					if (current_floor == lot_pkg::floor_t'(1))
						state <= (moving != '0) ? st_deliver : st_idle;
				end
				st_deliver: begin
					car_out <= 1'b1;
					moving <= '0;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Result payload, captured at take and at the lobby
	always_ff @(posedge clock) begin
		if (take)
			car_out_fee <= slot_fee;
		if (state == st_deliver)
			car_out_plate <= moving;
	end

	// Every trip goes to a real floor of the tower and never overshoots it
	assert property (@(posedge clock) disable iff (reset)
		state != st_idle |-> lot_pkg::slot_floor(target_slot) != '0);
	assert property (@(posedge clock) disable iff (reset)
		(state == st_climb_park || state == st_climb_fetch)
			|-> current_floor <= lot_pkg::slot_floor(target_slot));

endmodule

// File: design/parking_lot_top.sv
// ------------------------------
// Parking tower top, connects queue, finder, table, fee meters and elevator
// ------------------------------
module parking_lot_top #(
	parameter int QUEUE_DEPTH = 8,
	parameter int FEE_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	input logic park,
	input logic fetch,
	input vehicle_pkg::plate_t plate,
	output lot_pkg::slot_plates_t slot_plates,
	output lot_pkg::floor_t current_floor,
	output vehicle_pkg::plate_t moving,
	output logic [3:0] empty_suv,
	output logic [3:0] empty_sedan,
	output logic full_suv,
	output logic full_sedan,
	output logic car_out,
	output vehicle_pkg::plate_t car_out_plate,
	output logic [FEE_WIDTH-1:0] car_out_fee,
	output logic order_reject
);

	logic ready;
	logic order_park;
	logic order_fetch;
	vehicle_pkg::plate_t order_plate;
	lot_pkg::slot_t park_slot;
	logic park_found;
	lot_pkg::slot_t fetch_slot;
	logic fetch_found;
	logic store;
	logic take;
	lot_pkg::slot_t target_slot;
	logic [FEE_WIDTH-1:0] slot_fee;

	order_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
		.clock(clock), .reset(reset), .park(park), .fetch(fetch), .plate(plate),
		.ready(ready), .order_park(order_park), .order_fetch(order_fetch),
		.order_plate(order_plate)
	);

	spot_finder finder_i (
		.slot_plates(slot_plates), .full_sedan(full_sedan), .order_plate(order_plate),
		.park_slot(park_slot), .park_found(park_found),
		.fetch_slot(fetch_slot), .fetch_found(fetch_found)
	);

	slot_table table_i (
		.clock(clock), .reset(reset), .store(store), .take(take),
		.target_slot(target_slot), .moving(moving), .slot_plates(slot_plates),
		.empty_suv(empty_suv), .empty_sedan(empty_sedan),
		.full_suv(full_suv), .full_sedan(full_sedan)
	);

	fee_bank #(.FEE_WIDTH(FEE_WIDTH)) fees_i (
		.clock(clock), .reset(reset), .slot_plates(slot_plates),
		.target_slot(target_slot), .slot_fee(slot_fee)
	);

	elevator_controller #(.FEE_WIDTH(FEE_WIDTH)) elevator_i (
		.clock(clock), .reset(reset),
		.order_park(order_park), .order_fetch(order_fetch), .order_plate(order_plate),
		.park_slot(park_slot), .park_found(park_found),
		.fetch_slot(fetch_slot), .fetch_found(fetch_found), .slot_fee(slot_fee),
		.ready(ready), .store(store), .take(take), .target_slot(target_slot),
		.current_floor(current_floor), .moving(moving),
		.car_out(car_out), .car_out_plate(car_out_plate), .car_out_fee(car_out_fee),
		.order_reject(order_reject)
	);

endmodule

// File: bench/parking_checker.sv
// ------------------------------
// Watches the tower ports, keeps a slot and fee model, checks every order result
// ------------------------------
module parking_checker #(
	parameter int FEE_WIDTH = 8
) (
	input logic clock,
	input logic reset,
	input lot_pkg::slot_plates_t slot_plates,
	input lot_pkg::floor_t current_floor,
	input vehicle_pkg::plate_t moving,
	input logic [3:0] empty_suv,
	input logic [3:0] empty_sedan,
	input logic full_suv,
	input logic full_sedan,
	input logic car_out,
	input vehicle_pkg::plate_t car_out_plate,
	input logic [FEE_WIDTH-1:0] car_out_fee,
	input logic order_reject,
	output int done_count,
	output int error_count
);

	localparam int LO = lot_pkg::FIRST_SLOT;
	localparam int HI = lot_pkg::LAST_SLOT;

	logic exp_fetch [$];
	vehicle_pkg::plate_t exp_plate [$];
	int exp_slot [$];
	logic exp_reject [$];

	vehicle_pkg::plate_t model [LO:HI]; // Last seen plate per space
	int visible [LO:HI]; // Occupied cycles seen so far
	lot_pkg::floor_t prev_floor; // Elevator floor one cycle back
	vehicle_pkg::plate_t prev_moving; // Car on board one cycle back
	logic taken;
	int taken_fee;
	int test_errors;

	initial begin
		done_count = 0;
		error_count = 0;
		test_errors = 0;
		taken = 1'b0;
		taken_fee = 0;
		prev_floor = '0;
		prev_moving = '0;
		for (int s = LO; s <= HI; s++) begin
			model[s] = '0;
			visible[s] = 0;
		end
	end

	task automatic expect_order(input logic is_fetch, input vehicle_pkg::plate_t p,
			input int slot, input logic reject);
		exp_fetch.push_back(is_fetch);
		exp_plate.push_back(p);
		exp_slot.push_back(slot);
		exp_reject.push_back(reject);
	endtask

	function automatic logic odd_floor(int s);
		return ((s / 2) % 2) == 1;
	endfunction

	function automatic logic slot_reserved(int s);
		return (s == 2 || s == 4); // Left spaces of floors 1 and 2
	endfunction

	function automatic int class_rate(vehicle_pkg::plate_t p);
		if (p[15:12] == vehicle_pkg::PREFIX_HANDICAP)
			return 0;
		if (p[15:12] == vehicle_pkg::PREFIX_HYBRID)
			return 1;
		return 2;
	endfunction

	function automatic int billed(int rate, int cycles);
		int max_fee;
		max_fee = (1 << FEE_WIDTH) - 1;
		return (rate * cycles > max_fee) ? max_fee : rate * cycles;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("mismatch %s: got %h expected %h", name, got, want);
		error_count++;
		test_errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("error: %s", msg);
		error_count++;
		test_errors++;
	endtask

	task automatic close_test(input string kind);
		if (test_errors == 0)
			$display("test %0d %s %h: ok", done_count + 1, kind, exp_plate[0]);
		else
			$display("test %0d %s %h: FAILED", done_count + 1, kind, exp_plate[0]);
		void'(exp_fetch.pop_front());
		void'(exp_plate.pop_front());
		void'(exp_slot.pop_front());
		void'(exp_reject.pop_front());
		done_count++;
		test_errors = 0;
	endtask

	// Store happened a cycle ago at the space's floor, with the car still on board
	task automatic check_store(input int s, input vehicle_pkg::plate_t cur);
		if (exp_fetch.size() == 0 || exp_fetch[0] || exp_reject[0]) begin
			report_problem($sformatf("slot %0d filled with no park order due", s));
		end else begin
			if (s != exp_slot[0])
				report_mismatch("store slot", 32'(s), 32'(exp_slot[0]));
			if (cur != exp_plate[0])
				report_mismatch("slot_plates", 32'(cur), 32'(exp_plate[0]));
			if (32'(prev_floor) != 32'(s / 2))
				report_mismatch("current_floor", 32'(prev_floor), 32'(s / 2));
			if (prev_moving != cur)
				report_mismatch("moving", 32'(prev_moving), 32'(cur));
			if (moving != '0)
				report_mismatch("moving", 32'(moving), 32'(0));
			close_test("park");
		end
	endtask

	task automatic check_take(input int s);
		if (exp_fetch.size() == 0 || !exp_fetch[0] || exp_reject[0] || taken) begin
			report_problem($sformatf("slot %0d emptied with no fetch order due", s));
		end else begin
			if (s != exp_slot[0])
				report_mismatch("take slot", 32'(s), 32'(exp_slot[0]));
			if (model[s] != exp_plate[0])
				report_mismatch("taken plate", 32'(model[s]), 32'(exp_plate[0]));
			if (32'(prev_floor) != 32'(s / 2))
				report_mismatch("current_floor", 32'(prev_floor), 32'(s / 2));
			if (moving != model[s])
				report_mismatch("moving", 32'(moving), 32'(model[s]));
			taken = 1'b1;
			taken_fee = billed(class_rate(model[s]), visible[s]);
		end
	endtask

	// Outputs settle after the rising edge, so everything is sampled on the falling one
	always @(negedge clock) begin
		vehicle_pkg::plate_t cur;
		int suv;
		int sedan;
		int step;
		if (!reset) begin
			for (int s = LO; s <= HI; s++) begin
				cur = slot_plates[s];
				if (cur != model[s]) begin
					if (model[s] == '0)
						check_store(s, cur);
					else if (cur == '0)
						check_take(s);
					else
						report_problem($sformatf("slot %0d swapped plates", s));
					model[s] = cur;
				end
				if (cur != '0)
					visible[s]++;
				else
					visible[s] = 0;
			end
			if (order_reject) begin
				if (exp_reject.size() == 0 || !exp_reject[0]) begin
					report_problem("order_reject pulsed for a serviceable order");
				end else begin
					if (current_floor != '0)
						report_mismatch("current_floor", 32'(current_floor), 32'(0));
					if (moving != '0)
						report_mismatch("moving", 32'(moving), 32'(0));
					close_test("reject");
				end
			end
			if (car_out) begin
				if (exp_fetch.size() == 0 || !exp_fetch[0] || !taken) begin
					report_problem("car_out pulsed with no car taken");
				end else begin
					if (car_out_plate != exp_plate[0])
						report_mismatch("car_out_plate", 32'(car_out_plate), 32'(exp_plate[0]));
					if (32'(car_out_fee) != 32'(taken_fee))
						report_mismatch("car_out_fee", 32'(car_out_fee), 32'(taken_fee));
					if (current_floor != '0)
						report_mismatch("current_floor", 32'(current_floor), 32'(0));
					if (moving != '0)
						report_mismatch("moving", 32'(moving), 32'(0));
					taken = 1'b0;
					close_test("fetch");
				end
			end
			// One floor per cycle at most
			step = int'(current_floor) - int'(prev_floor);
			if (step > 1 || step < -1)
				report_problem($sformatf("elevator jumped from floor %0d to floor %0d",
					prev_floor, current_floor));
			suv = 0;
			sedan = 0;
			for (int s = LO; s <= HI; s++) begin
				if (model[s] == '0 && !slot_reserved(s)) begin
					if (odd_floor(s))
						suv++;
					else
						sedan++;
				end
			end
			if (32'(empty_suv) != 32'(suv))
				report_mismatch("empty_suv", 32'(empty_suv), 32'(suv));
			if (32'(empty_sedan) != 32'(sedan))
				report_mismatch("empty_sedan", 32'(empty_sedan), 32'(sedan));
			if (full_suv != (suv == 0))
				report_mismatch("full_suv", 32'(full_suv), 32'(suv == 0));
			if (full_sedan != (sedan == 0))
				report_mismatch("full_sedan", 32'(full_sedan), 32'(sedan == 0));
			prev_floor = current_floor;
			prev_moving = moving;
		end
	end

endmodule

// File: bench/parking_lot_tb.sv
// ------------------------------
// Tower testbench, replays the order list from the data file into the DUT
// ------------------------------
module parking_lot_tb;

	localparam int WAIT_LIMIT = 600; // Cycles allowed for pending orders to finish

	logic clock;
	logic reset;
	logic park;
	logic fetch;
	vehicle_pkg::plate_t plate;
	lot_pkg::slot_plates_t slot_plates;
	lot_pkg::floor_t current_floor;
	vehicle_pkg::plate_t moving;
	logic [3:0] empty_suv;
	logic [3:0] empty_sedan;
	logic full_suv;
	logic full_sedan;
	logic car_out;
	vehicle_pkg::plate_t car_out_plate;
	logic [7:0] car_out_fee;
	logic order_reject;
	int done_count;
	int error_count;
	int issued;
	logic timed_out;

	parking_lot_top #(.QUEUE_DEPTH(8), .FEE_WIDTH(8)) dut_i (
		.clock(clock), .reset(reset), .park(park), .fetch(fetch), .plate(plate),
		.slot_plates(slot_plates), .current_floor(current_floor), .moving(moving),
		.empty_suv(empty_suv), .empty_sedan(empty_sedan),
		.full_suv(full_suv), .full_sedan(full_sedan),
		.car_out(car_out), .car_out_plate(car_out_plate), .car_out_fee(car_out_fee),
		.order_reject(order_reject)
	);

	parking_checker #(.FEE_WIDTH(8)) checker_i (
		.clock(clock), .reset(reset), .slot_plates(slot_plates),
		.current_floor(current_floor), .moving(moving),
		.empty_suv(empty_suv), .empty_sedan(empty_sedan),
		.full_suv(full_suv), .full_sedan(full_sedan),
		.car_out(car_out), .car_out_plate(car_out_plate), .car_out_fee(car_out_fee),
		.order_reject(order_reject), .done_count(done_count), .error_count(error_count)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Called at 1 unit past an edge, returns at the same phase
	task automatic send_order(input logic is_fetch, input vehicle_pkg::plate_t p);
		park = !is_fetch;
		fetch = is_fetch;
		plate = p;
		@(posedge clock);
		#1;
		park = 1'b0;
		fetch = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (done_count != issued && n < WAIT_LIMIT) begin
			@(posedge clock);
			n++;
		end
		#1;
		if (done_count != issued) begin
			$display("timeout: %0d of %0d orders still open after %0d cycles",
				issued - done_count, issued, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		int fd;
		int n;
		int gap;
		string line;
		string op;
		logic [31:0] value;
		int fl;
		int sp;
		logic bad_file;
		park = 1'b0;
		fetch = 1'b0;
		plate = '0;
		reset = 1'b1;
		issued = 0;
		timed_out = 1'b0;
		bad_file = 1'b0;
		void'($urandom(32'h3f34_4c7c));
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		fd = $fopen("bench/parking_testdata.txt", "r");
		if (fd == 0) begin
			$display("error: the order data file could not be opened");
			bad_file = 1'b1;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == 8'h23) // Blank or # comment
					continue;
				n = $sscanf(line, "%s %h %d %d", op, value, fl, sp);
				if (n != 4) begin
					$display("error: unreadable data line: %s", line);
					bad_file = 1'b1;
				end else if (op == "w") begin
					wait_done();
					gap = int'(value) + 1 + int'($urandom % 4);
					repeat (gap) @(posedge clock);
					#1;
				end else begin
					checker_i.expect_order(op == "f", value[15:0], fl * 2 + sp, fl == 0);
					issued++;
					send_order(op == "f", value[15:0]);
				end
			end
			$fclose(fd);
			if (!timed_out)
				wait_done();
		end
		$display("orders %0d, finished %0d, errors %0d", issued, done_count, error_count);
		if (error_count == 0 && !timed_out && !bad_file && done_count == issued) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: bench/parking_testdata.txt
# op plate(hex) floor space : p park, f fetch, floor 0 expects a reject
# w count 0 0 : wait for open orders, then idle count cycles
p 1001 1 1
p 1002 2 1
p 8003 3 0
p 9005 1 0
p 9006 2 0
p 1004 4 0
p 8008 4 1
p 100a 6 0
w 5 0 0
p 100c 6 1
p 100e 3 1
p 9010 5 0
w 3 0 0
f 1002 2 1
p 1012 2 1
f 9005 1 0
p 1013 5 1
p 1014 7 0
p 1015 7 1
p 1017 0 0
w 4 0 0
f 7777 0 0
f 8003 3 0
f 1001 1 1
p 9018 1 0
w 2 0 0
f 9010 5 0
f 1014 7 0
f 100e 3 1
w 3 0 0

// File: verilog.f
design/vehicle_pkg.sv
design/lot_pkg.sv
design/order_queue.sv
design/spot_finder.sv
design/slot_table.sv
design/fee_bank.sv
design/elevator_controller.sv
design/parking_lot_top.sv
bench/parking_checker.sv
bench/parking_lot_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the parking tower simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module parking_lot_tb -o parking_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/parking_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	exit 0
fi
exit 1
